// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // Datapath and register index widths
  parameter int xlen = 32;
  parameter int reg_aw = 5;
  parameter int alu_w = 4;

  // ------------------------------
  // Major opcodes of the subset
  // ------------------------------
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 codes for ALU ops (ADD also covers SUB and ADDI)
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl = 3'b101;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // Whole-word load/store and branch conditions
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;

  // funct7 of SUB, imm field of EBREAK
  localparam logic [6:0] f7_alt = 7'b0100000;
  localparam logic [11:0] sys_ebreak = 12'h001;

  // ------------------------------
  // ALU operation codes
  // ------------------------------
  localparam logic [alu_w-1:0] alu_add = 4'd0;
  localparam logic [alu_w-1:0] alu_sub = 4'd1;
  localparam logic [alu_w-1:0] alu_and = 4'd2;
  localparam logic [alu_w-1:0] alu_or  = 4'd3;
  localparam logic [alu_w-1:0] alu_xor = 4'd4;
  localparam logic [alu_w-1:0] alu_slt = 4'd5;
  localparam logic [alu_w-1:0] alu_sll = 4'd6;
  localparam logic [alu_w-1:0] alu_srl = 4'd7;

  // Bubble word, ADDI x0, x0, 0
  localparam logic [31:0] instr_nop = 32'h0000_0013;

  // One instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
  } instr_t;

endpackage

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [rv_pkg::reg_aw-1:0] rs1_addr,
  input  logic [rv_pkg::reg_aw-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]   rs1_data,
  output logic [rv_pkg::xlen-1:0]   rs2_data,
  input  logic                      we,
  input  logic [rv_pkg::reg_aw-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]   rd_data
);

  import rv_pkg::*;

  // x1..x31, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  // Read port with x0 at zero and the write-back value bypassed in
  function automatic logic [xlen-1:0] read_port(input logic [reg_aw-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (we && (rd == addr)) begin
      return rd_data;
    end else begin
      return regs[addr];
    end
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    halt,
  input  logic                    redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_pc,
  output logic [rv_pkg::xlen-1:0] imem_raddr,
  input  logic [rv_pkg::xlen-1:0] imem_rdata,
  output rv_pkg::instr_t          instr_id,
  output logic [rv_pkg::xlen-1:0] pc_id
);

  import rv_pkg::*;

  logic [xlen-1:0] pc;

  // Zero-latency memory, the word comes back this cycle
  assign imem_raddr = pc;

  // Halt freezes the PC for good, redirect beats the stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (halt) begin
      pc <= pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // ------------------------------
  // Fetch/decode register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_id <= instr_nop;
      pc_id    <= reset_pc;
    end else if (flush) begin
      // Wrong-path word turns into a bubble
      instr_id <= instr_nop;
      pc_id    <= pc;
    end else if (!stall && !halt) begin
      instr_id <= imem_rdata;
      pc_id    <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  logic                      flush,
  input  rv_pkg::instr_t            instr_id,
  input  logic [rv_pkg::xlen-1:0]   pc_id,
  output logic [rv_pkg::reg_aw-1:0] rs1_addr,
  output logic [rv_pkg::reg_aw-1:0] rs2_addr,
  output logic                      rs1_used,
  output logic                      rs2_used,
  input  logic [rv_pkg::xlen-1:0]   rs1_data,
  input  logic [rv_pkg::xlen-1:0]   rs2_data,
  output logic [rv_pkg::alu_w-1:0]  alu_op,
  output logic                      use_imm,
  output logic                      is_lui,
  output logic                      is_branch,
  output logic                      branch_ne,
  output logic                      is_jal,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      reg_write,
  output logic                      is_halt,
  output logic [rv_pkg::reg_aw-1:0] rd_ex,
  output logic [rv_pkg::xlen-1:0]   imm_ex,
  output logic [rv_pkg::xlen-1:0]   rs1_data_ex,
  output logic [rv_pkg::xlen-1:0]   rs2_data_ex,
  output logic [rv_pkg::xlen-1:0]   pc_ex
);

  import rv_pkg::*;

  // Decoded control, before the decode/execute register
  logic [alu_w-1:0] alu_op_d;
  logic             use_imm_d;
  logic             is_lui_d;
  logic             is_branch_d;
  logic             branch_ne_d;
  logic             is_jal_d;
  logic             mem_read_d;
  logic             mem_write_d;
  logic             reg_write_d;
  logic             is_halt_d;
  logic [xlen-1:0]  imm_d;

  // Immediates of each format
  logic [xlen-1:0]  i_imm;
  logic [xlen-1:0]  s_imm;
  logic [xlen-1:0]  b_imm;
  logic [xlen-1:0]  u_imm;
  logic [xlen-1:0]  j_imm;

  // Source indices sit at the same bits in every format
  assign rs1_addr = instr_id.r_fmt.rs1;
  assign rs2_addr = instr_id.r_fmt.rs2;

  // ------------------------------
  // Immediate generation
  // ------------------------------
  assign i_imm = {{20{instr_id.i_fmt.imm[11]}}, instr_id.i_fmt.imm};
  assign s_imm = {{20{instr_id.s_fmt.imm_hi[6]}}, instr_id.s_fmt.imm_hi,
                  instr_id.s_fmt.imm_lo};
  assign b_imm = {{19{instr_id.b_fmt.imm_12}}, instr_id.b_fmt.imm_12,
                  instr_id.b_fmt.imm_11, instr_id.b_fmt.imm_10_5,
                  instr_id.b_fmt.imm_4_1, 1'b0};

  // U keeps the upper twenty bits as they are
  assign u_imm = {instr_id.r_fmt.funct7, instr_id.r_fmt.rs2, instr_id.r_fmt.rs1,
                  instr_id.r_fmt.funct3, 12'h000};

  // J scatters imm[19:12] over the rs1 and funct3 fields
  assign j_imm = {{11{instr_id.i_fmt.imm[11]}}, instr_id.i_fmt.imm[11],
                  instr_id.i_fmt.rs1, instr_id.i_fmt.funct3,
                  instr_id.i_fmt.imm[0], instr_id.i_fmt.imm[10:1], 1'b0};

  // ------------------------------
  // Control decode
  // ------------------------------
  always_comb begin
    alu_op_d    = alu_add;
    use_imm_d   = 1'b0;
    is_lui_d    = 1'b0;
    is_branch_d = 1'b0;
    branch_ne_d = 1'b0;
    is_jal_d    = 1'b0;
    mem_read_d  = 1'b0;
    mem_write_d = 1'b0;
    reg_write_d = 1'b0;
    is_halt_d   = 1'b0;
    rs1_used    = 1'b0;
    rs2_used    = 1'b0;
    imm_d       = i_imm;

    case (instr_id.r_fmt.opcode)
      op_reg: begin
        rs1_used    = 1'b1;
        rs2_used    = 1'b1;
        reg_write_d = 1'b1;
        case (instr_id.r_fmt.funct3)
          f3_add: alu_op_d = (instr_id.r_fmt.funct7 == f7_alt) ? alu_sub : alu_add;
          f3_sll: alu_op_d = alu_sll;
          f3_slt: alu_op_d = alu_slt;
          f3_xor: alu_op_d = alu_xor;
          f3_srl: alu_op_d = alu_srl;
          f3_or:  alu_op_d = alu_or;
          f3_and: alu_op_d = alu_and;
          // Unsupported funct3 retires as a bubble
          default: reg_write_d = 1'b0;
        endcase
      end
      op_imm: begin
        // ADDI only
        if (instr_id.i_fmt.funct3 == f3_add) begin
          rs1_used    = 1'b1;
          use_imm_d   = 1'b1;
          reg_write_d = 1'b1;
        end
      end
      op_lui: begin
        is_lui_d    = 1'b1;
        use_imm_d   = 1'b1;
        reg_write_d = 1'b1;
        imm_d       = u_imm;
      end
      op_load: begin
        if (instr_id.i_fmt.funct3 == f3_word) begin
          rs1_used    = 1'b1;
          use_imm_d   = 1'b1;
          mem_read_d  = 1'b1;
          reg_write_d = 1'b1;
        end
      end
      op_store: begin
        if (instr_id.s_fmt.funct3 == f3_word) begin
          rs1_used    = 1'b1;
          rs2_used    = 1'b1;
          use_imm_d   = 1'b1;
          mem_write_d = 1'b1;
          imm_d       = s_imm;
        end
      end
      op_branch: begin
        if ((instr_id.b_fmt.funct3 == f3_beq) || (instr_id.b_fmt.funct3 == f3_bne)) begin
          rs1_used    = 1'b1;
          rs2_used    = 1'b1;
          is_branch_d = 1'b1;
          branch_ne_d = (instr_id.b_fmt.funct3 == f3_bne);
          imm_d       = b_imm;
        end
      end
      op_jal: begin
        is_jal_d    = 1'b1;
        reg_write_d = 1'b1;
        imm_d       = j_imm;
      end
      op_system: begin
        is_halt_d = (instr_id.i_fmt.imm == sys_ebreak);
      end
      default: begin
      end
    endcase
  end

  // ------------------------------
  // Decode/execute register
  // ------------------------------

  // Control bits, cleared to a bubble on stall or flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      is_branch <= 1'b0;
      is_jal    <= 1'b0;
      mem_read  <= 1'b0;
      mem_write <= 1'b0;
      reg_write <= 1'b0;
      is_halt   <= 1'b0;
    end else if (stall || flush) begin
      is_branch <= 1'b0;
      is_jal    <= 1'b0;
      mem_read  <= 1'b0;
      mem_write <= 1'b0;
      reg_write <= 1'b0;
      is_halt   <= 1'b0;
    end else begin
      is_branch <= is_branch_d;
      is_jal    <= is_jal_d;
      mem_read  <= mem_read_d;
      mem_write <= mem_write_d;
      reg_write <= reg_write_d;
      is_halt   <= is_halt_d;
    end
  end

  // Operands and qualifiers, meaningless under a bubble
  always_ff @(posedge clk) begin
    alu_op      <= alu_op_d;
    use_imm     <= use_imm_d;
    is_lui      <= is_lui_d;
    branch_ne   <= branch_ne_d;
    rd_ex       <= instr_id.r_fmt.rd;
    imm_ex      <= imm_d;
    rs1_data_ex <= rs1_data;
    rs2_data_ex <= rs2_data;
    pc_ex       <= pc_id;
  end

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [rv_pkg::alu_w-1:0]  alu_op,
  input  logic                      use_imm,
  input  logic                      is_lui,
  input  logic                      is_branch,
  input  logic                      branch_ne,
  input  logic                      is_jal,
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  logic                      reg_write,
  input  logic                      is_halt,
  input  logic [rv_pkg::reg_aw-1:0] rd_ex,
  input  logic [rv_pkg::xlen-1:0]   imm_ex,
  input  logic [rv_pkg::xlen-1:0]   rs1_data_ex,
  input  logic [rv_pkg::xlen-1:0]   rs2_data_ex,
  input  logic [rv_pkg::xlen-1:0]   pc_ex,
  output logic                      redirect,
  output logic [rv_pkg::xlen-1:0]   redirect_pc,
  output logic [rv_pkg::xlen-1:0]   result_mem,
  output logic [rv_pkg::xlen-1:0]   store_data_mem,
  output logic [rv_pkg::reg_aw-1:0] rd_mem,
  output logic                      mem_read_mem,
  output logic                      mem_write_mem,
  output logic                      reg_write_mem,
  output logic                      halt_mem,
  output logic [rv_pkg::reg_aw-1:0] rd_ex_haz,
  output logic                      reg_write_ex_haz
);

  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] result;
  logic            taken;

  // LUI adds its immediate to zero
  assign op_a = is_lui ? '0 : rs1_data_ex;
  assign op_b = use_imm ? imm_ex : rs2_data_ex;

  // ------------------------------
  // ALU
  // ------------------------------
  always_comb begin
    case (alu_op)
      alu_sub: alu_res = op_a - op_b;
      alu_and: alu_res = op_a & op_b;
      alu_or:  alu_res = op_a | op_b;
      alu_xor: alu_res = op_a ^ op_b;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      // Shift amount is the low five bits only
      alu_sll: alu_res = op_a << op_b[4:0];
      alu_srl: alu_res = op_a >> op_b[4:0];
      default: alu_res = op_a + op_b;
    endcase
  end

  // Branch resolves here, BNE inverts the equality
  assign taken       = is_branch && ((rs1_data_ex == rs2_data_ex) ^ branch_ne);
  assign redirect    = taken || is_jal;
  assign redirect_pc = pc_ex + imm_ex;

  // JAL links the return address
  assign result = is_jal ? (pc_ex + 32'd4) : alu_res;

  // Pending destination seen by the hazard unit
  assign rd_ex_haz        = rd_ex;
  assign reg_write_ex_haz = reg_write;

  // ------------------------------
  // Execute/memory register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_read_mem  <= 1'b0;
      mem_write_mem <= 1'b0;
      reg_write_mem <= 1'b0;
      halt_mem      <= 1'b0;
    end else begin
      mem_read_mem  <= mem_read;
      mem_write_mem <= mem_write;
      reg_write_mem <= reg_write;
      halt_mem      <= is_halt;
    end
  end

  always_ff @(posedge clk) begin
    result_mem     <= result;
    store_data_mem <= rs2_data_ex;
    rd_mem         <= rd_ex;
  end

endmodule

`default_nettype wire

// ==== logic/rv_mem_wb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_mem_wb (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [rv_pkg::xlen-1:0]   result_mem,
  input  logic [rv_pkg::xlen-1:0]   store_data_mem,
  input  logic [rv_pkg::reg_aw-1:0] rd_mem,
  input  logic                      mem_read_mem,
  input  logic                      mem_write_mem,
  input  logic                      reg_write_mem,
  input  logic                      halt_mem,
  output logic                      dmem_ren,
  output logic [rv_pkg::xlen-1:0]   dmem_raddr,
  input  logic [rv_pkg::xlen-1:0]   dmem_rdata,
  output logic                      dmem_we,
  output logic [rv_pkg::xlen-1:0]   dmem_waddr,
  output logic [rv_pkg::xlen-1:0]   dmem_wdata,
  output logic                      wb_we,
  output logic [rv_pkg::reg_aw-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]   wb_data,
  output logic                      ebreak
);

  import rv_pkg::*;

  // Sticky, set once EBREAK enters write-back
  logic halt_q;

  // ------------------------------
  // Data memory access
  // ------------------------------

  // Nothing behind the EBREAK touches memory
  assign dmem_ren   = mem_read_mem && !halt_q;
  assign dmem_raddr = result_mem;
  assign dmem_we    = mem_write_mem && !halt_q;
  assign dmem_waddr = result_mem;
  assign dmem_wdata = store_data_mem;

  // Memory/write-back register, halt flag included
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we  <= 1'b0;
      halt_q <= 1'b0;
    end else begin
      wb_we  <= reg_write_mem && !halt_q;
      halt_q <= halt_q || halt_mem;
    end
  end

  // Result mux, load data or ALU result
  always_ff @(posedge clk) begin
    wb_rd   <= rd_mem;
    wb_data <= mem_read_mem ? dmem_rdata : result_mem;
  end

  assign ebreak = halt_q;

endmodule

`default_nettype wire

// ==== logic/rv_hazard.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_hazard (
  input  logic [rv_pkg::reg_aw-1:0] rs1_addr,
  input  logic [rv_pkg::reg_aw-1:0] rs2_addr,
  input  logic                      rs1_used,
  input  logic                      rs2_used,
  input  logic [rv_pkg::reg_aw-1:0] rd_ex_haz,
  input  logic                      reg_write_ex_haz,
  input  logic [rv_pkg::reg_aw-1:0] rd_mem,
  input  logic                      reg_write_mem,
  input  logic                      redirect,
  output logic                      stall,
  output logic                      flush
);

  import rv_pkg::*;

  logic rs1_hit;
  logic rs2_hit;

  // Source matches a writer still in execute or memory
  // Write-back is covered by the register file bypass
  function automatic logic pending(input logic [reg_aw-1:0] rs, input logic used);
    return used && (rs != '0) &&
           ((reg_write_ex_haz && (rs == rd_ex_haz)) || (reg_write_mem && (rs == rd_mem)));
  endfunction

  assign rs1_hit = pending(rs1_addr, rs1_used);
  assign rs2_hit = pending(rs2_addr, rs2_used);

  // Redirect kills the stalled instruction anyway
  assign flush = redirect;
  assign stall = (rs1_hit || rs2_hit) && !redirect;

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rv_pkg::xlen-1:0] imem_raddr,
  input  logic [rv_pkg::xlen-1:0] imem_rdata,
  output logic                    dmem_ren,
  output logic [rv_pkg::xlen-1:0] dmem_raddr,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic                    dmem_we,
  output logic [rv_pkg::xlen-1:0] dmem_waddr,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  output logic                    ebreak
);

  import rv_pkg::*;

  // ------------------------------
  // Stage to stage wiring
  // ------------------------------

  // Fetch to decode
  instr_t            instr_id;
  logic [xlen-1:0]   pc_id;

  // Decode to register file and hazard unit
  logic [reg_aw-1:0] rs1_addr;
  logic [reg_aw-1:0] rs2_addr;
  logic              rs1_used;
  logic              rs2_used;
  logic [xlen-1:0]   rs1_data;
  logic [xlen-1:0]   rs2_data;

  // Decode to execute
  logic [alu_w-1:0]  alu_op;
  logic              use_imm;
  logic              is_lui;
  logic              is_branch;
  logic              branch_ne;
  logic              is_jal;
  logic              mem_read;
  logic              mem_write;
  logic              reg_write;
  logic              is_halt;
  logic [reg_aw-1:0] rd_ex;
  logic [xlen-1:0]   imm_ex;
  logic [xlen-1:0]   rs1_data_ex;
  logic [xlen-1:0]   rs2_data_ex;
  logic [xlen-1:0]   pc_ex;

  // Execute to fetch, memory and hazard unit
  logic              redirect;
  logic [xlen-1:0]   redirect_pc;
  logic [xlen-1:0]   result_mem;
  logic [xlen-1:0]   store_data_mem;
  logic [reg_aw-1:0] rd_mem;
  logic              mem_read_mem;
  logic              mem_write_mem;
  logic              reg_write_mem;
  logic              halt_mem;
  logic [reg_aw-1:0] rd_ex_haz;
  logic              reg_write_ex_haz;

  // Write-back port of the register file
  logic              wb_we;
  logic [reg_aw-1:0] wb_rd;
  logic [xlen-1:0]   wb_data;

  // Pipeline control
  logic              stall;
  logic              flush;

  // ------------------------------
  // Stages
  // ------------------------------

  rv_fetch #(
    .reset_pc(reset_pc)
  ) u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .flush      (flush),
    .halt       (ebreak),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .instr_id   (instr_id),
    .pc_id      (pc_id)
  );

  rv_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .flush      (flush),
    .instr_id   (instr_id),
    .pc_id      (pc_id),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_used   (rs1_used),
    .rs2_used   (rs2_used),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .is_lui     (is_lui),
    .is_branch  (is_branch),
    .branch_ne  (branch_ne),
    .is_jal     (is_jal),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .reg_write  (reg_write),
    .is_halt    (is_halt),
    .rd_ex      (rd_ex),
    .imm_ex     (imm_ex),
    .rs1_data_ex(rs1_data_ex),
    .rs2_data_ex(rs2_data_ex),
    .pc_ex      (pc_ex)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (wb_we),
    .rd      (wb_rd),
    .rd_data (wb_data)
  );

  rv_execute u_execute (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_op          (alu_op),
    .use_imm         (use_imm),
    .is_lui          (is_lui),
    .is_branch       (is_branch),
    .branch_ne       (branch_ne),
    .is_jal          (is_jal),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .reg_write       (reg_write),
    .is_halt         (is_halt),
    .rd_ex           (rd_ex),
    .imm_ex          (imm_ex),
    .rs1_data_ex     (rs1_data_ex),
    .rs2_data_ex     (rs2_data_ex),
    .pc_ex           (pc_ex),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .result_mem      (result_mem),
    .store_data_mem  (store_data_mem),
    .rd_mem          (rd_mem),
    .mem_read_mem    (mem_read_mem),
    .mem_write_mem   (mem_write_mem),
    .reg_write_mem   (reg_write_mem),
    .halt_mem        (halt_mem),
    .rd_ex_haz       (rd_ex_haz),
    .reg_write_ex_haz(reg_write_ex_haz)
  );

  rv_mem_wb u_mem_wb (
    .clk           (clk),
    .rst_n         (rst_n),
    .result_mem    (result_mem),
    .store_data_mem(store_data_mem),
    .rd_mem        (rd_mem),
    .mem_read_mem  (mem_read_mem),
    .mem_write_mem (mem_write_mem),
    .reg_write_mem (reg_write_mem),
    .halt_mem      (halt_mem),
    .dmem_ren      (dmem_ren),
    .dmem_raddr    (dmem_raddr),
    .dmem_rdata    (dmem_rdata),
    .dmem_we       (dmem_we),
    .dmem_waddr    (dmem_waddr),
    .dmem_wdata    (dmem_wdata),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .ebreak        (ebreak)
  );

  rv_hazard u_hazard (
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .rs1_used        (rs1_used),
    .rs2_used        (rs2_used),
    .rd_ex_haz       (rd_ex_haz),
    .reg_write_ex_haz(reg_write_ex_haz),
    .rd_mem          (rd_mem),
    .reg_write_mem   (reg_write_mem),
    .redirect        (redirect),
    .stall           (stall),
    .flush           (flush)
  );

endmodule

`default_nettype wire

// ==== test/rv_core_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        ebreak,
  input logic        dmem_ren,
  input logic        dmem_we,
  input logic [31:0] imem_raddr
);

  // ------------------------------
  // Halt, memory strobes, fetch
  // ------------------------------

  // Halt only clears through reset
  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) ebreak |=> ebreak)
    else $error("ebreak dropped before reset");

  // One memory stage op, so read and write never overlap
  strobes_apart: assert property (@(posedge clk) disable iff (!rst_n) !(dmem_ren && dmem_we))
    else $error("dmem read and write strobes high together");

  fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n) imem_raddr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

endmodule

`default_nettype wire

// ==== test/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

  // One row per run of the fixed program
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  sel;
    logic [31:0] exp8;
    logic [31:0] exp12;
  } row_t;

  localparam int n_rows = 10;
  localparam int cycle_limit = n_rows * 60;

  // Selector: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sll, 7 srl
  // Word at 12 is 5 only when a equals b and BNE falls through
  localparam row_t rows [n_rows] = '{
    '{32'h0000_0005, 32'h0000_0007, 3'd0, 32'h0000_000c, 32'h0000_0000},
    '{32'h0000_0003, 32'h0000_000a, 3'd1, 32'hffff_fff9, 32'h0000_0000},
    '{32'hf0f0_1234, 32'h0ff0_ff00, 3'd2, 32'h00f0_1200, 32'h0000_0000},
    '{32'h8000_0001, 32'h0000_00f0, 3'd3, 32'h8000_00f1, 32'h0000_0000},
    '{32'h1234_5678, 32'h1234_5678, 3'd4, 32'h0000_0000, 32'h0000_0005},
    '{32'hffff_fffd, 32'h0000_0002, 3'd5, 32'h0000_0001, 32'h0000_0000},
    '{32'h0000_0002, 32'hffff_fffd, 3'd5, 32'h0000_0000, 32'h0000_0000},
    '{32'h0000_0003, 32'h0000_0021, 3'd6, 32'h0000_0006, 32'h0000_0000},
    '{32'hf000_0000, 32'hffff_ffe4, 3'd7, 32'h0f00_0000, 32'h0000_0000},
    '{32'hffff_fff8, 32'hffff_fff8, 3'd1, 32'h0000_0000, 32'h0000_0005}
  };

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:15];
  logic [31:0] op_a;
  logic [31:0] op_b;
  int          writes = 0;
  int          cycles = 0;
  int          errors = 0;

  rv_core UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .ebreak    (ebreak)
  );

  bind rv_core rv_core_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .ebreak    (ebreak),
    .dmem_ren  (dmem_ren),
    .dmem_we   (dmem_we),
    .imem_raddr(imem_raddr)
  );

  // ------------------------------
  // Clock and memory models
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Both memories answer in the same cycle
  assign imem_rdata = imem[imem_raddr[7:2]];
  // Data word only valid while the read strobe is up
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[5:2]] : 'x;

  // Operands are reloaded while reset is held
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        dmem[i[3:0]] <= {28'hbad0000, i[3:0]};
      end
      dmem[0] <= op_a;
      dmem[1] <= op_b;
      writes  <= 0;
    end else if (dmem_we) begin
      dmem[dmem_waddr[5:2]] <= dmem_wdata;
      writes <= writes + 1;
    end
  end

  // Run limit over all rows
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the core did not reach EBREAK within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $fatal(1, "run limit reached");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic stop_on_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  // R-type x3 = x1 op x2 for the given selector
  function automatic logic [31:0] r_word(input logic [2:0] sel);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    case (sel)
      3'd1: begin
        f3 = 3'b000;
        f7 = 7'b0100000;
      end
      3'd2: f3 = 3'b111;
      3'd3: f3 = 3'b110;
      3'd4: f3 = 3'b100;
      3'd5: f3 = 3'b010;
      3'd6: f3 = 3'b001;
      3'd7: f3 = 3'b101;
      default: f3 = 3'b000;
    endcase
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  // Unused words hold ADDI x0, x0, index
  task automatic load_program(input logic [2:0] sel);
    for (int i = 0; i < 64; i++) begin
      imem[i[5:0]] = {6'd0, i[5:0], 5'd0, 3'b000, 5'd0, 7'b0010011};
    end
    imem[0]  = 32'h0000_2083;  // LW x1, 0(x0)
    imem[1]  = 32'h0040_2103;  // LW x2, 4(x0)
    imem[2]  = r_word(sel);
    imem[3]  = 32'h0030_2423;  // SW x3, 8(x0)
    imem[4]  = 32'h0020_9463;  // BNE x1, x2, +8
    imem[5]  = 32'h0050_0213;  // ADDI x4, x0, 5
    imem[6]  = 32'h0040_2623;  // SW x4, 12(x0)
    imem[7]  = 32'h0080_006f;  // JAL x0, +8
    imem[8]  = 32'h0070_0293;  // ADDI x5, x0, 7
    imem[9]  = 32'h0050_2823;  // SW x5, 16(x0)
    imem[10] = 32'h0010_0073;  // EBREAK
    imem[11] = 32'h0030_2a23;  // SW x3, 20(x0), behind the halt
  endtask

  // ------------------------------
  // One table row
  // ------------------------------
  task automatic run_row(input int r);
    row_t row;
    row = rows[r[3:0]];
    @(negedge clk);
    rst_n = 1'b0;
    op_a  = row.a;
    op_b  = row.b;
    load_program(row.sel);
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (ebreak === 1'b0) else begin
      stop_on_error($sformatf("row %0d ebreak is %b right after reset", r, ebreak));
    end
    while (ebreak !== 1'b1) begin
      @(negedge clk);
    end
    // A few cycles after halt to catch late stores
    repeat (4) @(negedge clk);
    check_word(dmem[2], row.exp8, $sformatf("row %0d word at 8", r));
    check_word(dmem[3], row.exp12, $sformatf("row %0d word at 12", r));
    check_word(dmem[4], 32'h0000_0000, $sformatf("row %0d word at 16", r));
    check_word(writes, 32'd3, $sformatf("row %0d store count", r));
  endtask

  initial begin
    rst_n = 1'b0;
    op_a  = 32'h0000_0000;
    op_b  = 32'h0000_0000;
    load_program(3'd0);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_mem_wb.sv
logic/rv_hazard.sv
logic/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f files.f -o rv_core_sim \
  && { ./obj_dir/rv_core_sim 2>&1 | tee sim.log; true; } \
  || { echo "Build failed"; exit 1; }

! grep -q "Simulation FAILED" sim.log && grep -q "Simulation PASSED" sim.log \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
